// ==== list.f ====
+incdir+tests
src/serial_line_pkg.sv
src/beacon_pkg.sv
src/reset_stretch.sv
src/uart_tx.sv
src/hex_beacon.sv
src/beacon_top.sv
tests/beacon_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the beacon testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module beacon_tb -f list.f -o beacon_sim &&
./obj_dir/beacon_sim | tee /dev/stderr | grep -q "Testbench passed" &&
echo "simulation run ok" ||
{ echo "simulation run not ok"; exit 1; }

// ==== src/beacon_pkg.sv ====
//////////////////////////////
// beacon message definitions
// pattern length, pacing, character codes
//////////////////////////////

package beacon_pkg;

	// clocks between character offers, longer than one 80 clock frame
	localparam int CHAR_INTERVAL = 128;
	localparam int PACE_W = $clog2(CHAR_INTERVAL);

	// hex characters before the line end
	localparam int HEX_RUN = 64;
	localparam int RUN_W = $clog2(HEX_RUN);

	// character codes
	localparam serial_line_pkg::serial_byte_t CHAR_DIGIT0 = 8'h30; // '0'
	localparam serial_line_pkg::serial_byte_t CHAR_LOWER_A = 8'h61; // 'a'
	localparam serial_line_pkg::serial_byte_t CHAR_CR = 8'h0d;
	localparam serial_line_pkg::serial_byte_t CHAR_LF = 8'h0a;

	// internal reset hold after rst_n lets go
	localparam int STRETCH_CYCLES = 16;
	localparam int STRETCH_W = $clog2(STRETCH_CYCLES + 1);

	typedef enum logic [1:0] {
		SEQ_HEX,
		SEQ_CR,
		SEQ_LF
	} seq_state_t;

endpackage

// ==== src/beacon_top.sv ====
//////////////////////////////
// serial test beacon top
// reset stretcher, sequencer and uart transmitter
//////////////////////////////

`timescale 1ns/1ns

module beacon_top (
	input  logic clock,
	input  logic rst_n,
	output logic tx,
	output serial_line_pkg::serial_byte_t char,
	output logic busy
);
	import serial_line_pkg::*;

	logic core_rst_n; // stretched reset for the core
	logic send;
	serial_byte_t char_net;
	logic busy_net;

	reset_stretch reset_stretch0 (
		.clock      (clock),
		.rst_n      (rst_n),
		.core_rst_n (core_rst_n)
	);

	hex_beacon hex_beacon0 (
		.clock (clock),
		.rst_n (core_rst_n),
		.busy  (busy_net),
		.send  (send),
		.char  (char_net)
	);

	uart_tx uart_tx0 (
		.clock (clock),
		.rst_n (core_rst_n),
		.send  (send),
		.char  (char_net),
		.tx    (tx),
		.busy  (busy_net)
	);

	// header pins and led
	assign char = char_net;
	assign busy = busy_net;

endmodule

// ==== src/hex_beacon.sv ====
//////////////////////////////
// hex beacon sequencer
// offers 0..f four times, then cr lf, one char per interval
//////////////////////////////

`timescale 1ns/1ns

module hex_beacon (
	input  logic clock,
	input  logic rst_n,
	input  logic busy,
	output logic send,
	output serial_line_pkg::serial_byte_t char
);
	import serial_line_pkg::*;
	import beacon_pkg::*;

	logic [PACE_W-1:0] pace;
	logic tick;
	seq_state_t seq;
	logic [RUN_W-1:0] run_pos; // position in the hex run

	// ascii for one hex digit, lower case letters
	function automatic serial_byte_t hex_code(input logic [3:0] digit);
		serial_byte_t code;
		if (digit < 4'd10) begin
			code = CHAR_DIGIT0 + serial_byte_t'(digit);
		end else begin
			code = CHAR_LOWER_A + serial_byte_t'(digit) - 8'd10;
		end
		return code;
	endfunction

	assign tick = (pace == PACE_W'(CHAR_INTERVAL - 1));

	// pacing counter, first tick one interval after reset release
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pace <= '0;
		end else if (tick) begin
			pace <= '0;
		end else begin
			pace <= pace + 1'b1;
		end
	end

	// a tick that finds the transmitter busy is simply skipped
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			send <= 1'b0;
		end else begin
			send <= tick && !busy;
		end
	end

	// advance one cycle after each send, char stays put until then
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			seq <= SEQ_HEX;
			run_pos <= '0;
		end else if (send) begin
			case (seq)
				SEQ_HEX: begin
					if (run_pos == RUN_W'(HEX_RUN - 1)) begin
						seq <= SEQ_CR;
						run_pos <= '0;
					end else begin
						run_pos <= run_pos + 1'b1;
					end
				end
				SEQ_CR: begin
					seq <= SEQ_LF;
				end
				SEQ_LF: begin
					seq <= SEQ_HEX; // back to '0'
				end
				default: begin
					seq <= SEQ_HEX;
					run_pos <= '0;
				end
			endcase
		end
	end

	// current character, also shown on the header pins
	always_comb begin
		case (seq)
			SEQ_CR: char = CHAR_CR;
			SEQ_LF: char = CHAR_LF;
			default: char = hex_code(run_pos[3:0]); // wraps every 16
		endcase
	end

	a_send_one_cycle: assert property (
		@(posedge clock) disable iff (!rst_n) send |=> !send
	);

endmodule

// ==== src/reset_stretch.sv ====
//////////////////////////////
// reset stretcher
// syncs the release of rst_n and holds the core in reset a while longer
//////////////////////////////

`timescale 1ns/1ns

module reset_stretch (
	input  logic clock,
	input  logic rst_n,
	output logic core_rst_n
);
	import beacon_pkg::*;

	logic sync_a;
	logic sync_b;
	logic [STRETCH_W-1:0] hold_cnt;

	// two flops on the release edge, assertion stays asynchronous
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			sync_a <= 1'b0;
			sync_b <= 1'b0;
		end else begin
			sync_a <= 1'b1;
			sync_b <= sync_a;
		end
	end

	// hold counter, lets the serial line settle before the first frame
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt <= '0;
			core_rst_n <= 1'b0;
		end else if (sync_b) begin
			if (hold_cnt == STRETCH_W'(STRETCH_CYCLES)) begin
				core_rst_n <= 1'b1;
			end else begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	// core leaves reset only after the whole stretch with rst_n high
	a_core_held: assert property (
		@(posedge clock) $rose(core_rst_n) |-> $past(rst_n, STRETCH_CYCLES + 2)
	);

endmodule

// ==== src/serial_line_pkg.sv ====
//////////////////////////////
// serial line definitions
// frame timing and transmitter states for 8N1
//////////////////////////////

package serial_line_pkg;

	// one character on the line
	typedef logic [7:0] serial_byte_t;

	// kept small so a frame fits a short simulation
	localparam int CLOCKS_PER_BIT = 8;
	localparam int FRAME_BITS = 10; // start, 8 data, stop

	localparam int BIT_CLK_W = $clog2(CLOCKS_PER_BIT);
	localparam int BIT_IDX_W = $clog2(FRAME_BITS);

	// line levels
	localparam logic LINE_IDLE = 1'b1;
	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT = 1'b1;

	typedef enum logic [1:0] {
		FS_IDLE,
		FS_START,
		FS_DATA,
		FS_STOP
	} frame_state_t;

endpackage

// ==== src/uart_tx.sv ====
//////////////////////////////
// uart transmitter
// 8N1 frame, lsb first, fixed bit period
//////////////////////////////

`timescale 1ns/1ns

module uart_tx (
	input  logic clock,
	input  logic rst_n,
	input  logic send,
	input  serial_line_pkg::serial_byte_t char,
	output logic tx,
	output logic busy
);
	import serial_line_pkg::*;

	frame_state_t state;
	logic [BIT_CLK_W-1:0] clk_cnt; // position inside the current bit
	logic [BIT_IDX_W-1:0] bit_idx; // frame bit on the line, 0 is start
	serial_byte_t shift_q;
	logic bit_end;

	assign bit_end = (clk_cnt == BIT_CLK_W'(CLOCKS_PER_BIT - 1));

	// high from the edge after send until the stop bit is over
	assign busy = (state != FS_IDLE);

	// bit period counter
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			clk_cnt <= '0;
		end else if (state == FS_IDLE || bit_end) begin
			clk_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// latched byte, shifted out lsb first
	always_ff @(posedge clock) begin
		if (state == FS_IDLE && send) begin
			shift_q <= char;
		end else if (bit_end && (state == FS_START || state == FS_DATA)) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= FS_IDLE;
			bit_idx <= '0;
			tx <= LINE_IDLE;
		end else begin
			case (state)
				FS_IDLE: begin
					if (send) begin // accepted in the send cycle
						state <= FS_START;
						bit_idx <= '0;
						tx <= START_BIT;
					end
				end
				FS_START: begin
					if (bit_end) begin
						state <= FS_DATA;
						bit_idx <= bit_idx + 1'b1;
						tx <= shift_q[0]; // data bit 0
					end
				end
				FS_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == BIT_IDX_W'(FRAME_BITS - 2)) begin
							state <= FS_STOP; // last data bit done
							tx <= STOP_BIT;
						end else begin
							tx <= shift_q[0];
						end
					end
				end
				FS_STOP: begin
					if (bit_end) begin
						state <= FS_IDLE;
						bit_idx <= '0;
						tx <= LINE_IDLE;
					end
				end
				default: begin
					state <= FS_IDLE;
					tx <= LINE_IDLE;
				end
			endcase
		end
	end

	// the beacon must wait for the line to be free
	a_no_send_when_busy: assert property (
		@(posedge clock) disable iff (!rst_n) send |-> !busy
	);

	a_idle_line_high: assert property (
		@(posedge clock) disable iff (!rst_n) (state == FS_IDLE) |-> tx
	);

endmodule

// ==== tests/beacon_vectors.svh ====
//////////////////////////////
// beacon expected characters
// one full pattern pass and the pass descriptors
//////////////////////////////

`ifndef BEACON_VECTORS_SVH
`define BEACON_VECTORS_SVH

// one expected character on the line
typedef struct packed {
	logic [7:0] idx;
	serial_line_pkg::serial_byte_t ch;
} expect_t;

localparam int TABLE_LEN = HEX_RUN + 2; // hex run, cr, lf
localparam int SECOND_PASS_LEN = 18;
localparam int PASS_COUNT = 2;

// digits in send order, leftmost is '0'
localparam logic [127:0] HEX_DIGITS = "0123456789abcdef";

expect_t expect_table [TABLE_LEN];

// both passes walk the table from entry 0
string pass_name [PASS_COUNT];
int pass_first [PASS_COUNT];
int pass_len [PASS_COUNT];

task automatic build_tables();
	for (int i = 0; i < HEX_RUN; i++) begin
		expect_table[i].idx = 8'(i);
		expect_table[i].ch = HEX_DIGITS[8 * (15 - (i % 16)) +: 8];
	end
	expect_table[HEX_RUN].idx = 8'(HEX_RUN);
	expect_table[HEX_RUN].ch = 8'h0d; // carriage return
	expect_table[HEX_RUN + 1].idx = 8'(HEX_RUN + 1);
	expect_table[HEX_RUN + 1].ch = 8'h0a; // line feed
	pass_name[0] = "first pass";
	pass_first[0] = 0;
	pass_len[0] = TABLE_LEN;
	pass_name[1] = "second pass";
	pass_first[1] = 0;
	pass_len[1] = SECOND_PASS_LEN; // wrap back to '0'
endtask

`endif

// ==== tests/beacon_tb.sv ====
//////////////////////////////
// beacon testbench
// decodes the serial line, checks pattern, timing and reset
//////////////////////////////

`timescale 1ns/1ns

module beacon_tb;
	import serial_line_pkg::*;
	import beacon_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 5;
	localparam int RESET_CYCLES = 3;
	// from the edge that first sees rst_n high to the first start edge
	localparam int START_DELAY = CHAR_INTERVAL + STRETCH_CYCLES + 3;
	localparam int START_WAIT_LIMIT = 2 * CHAR_INTERVAL;
	// stop bit mid sample to the point halfway between frames
	localparam int GAP_CLOCKS =
		(CHAR_INTERVAL - FRAME_BITS * CLOCKS_PER_BIT) / 2 + CLOCKS_PER_BIT / 2;
	localparam logic [7:0] LFSR_TAPS = 8'hb8;
	localparam logic [7:0] LFSR_SEED = 8'd14;
	localparam longint RUN_CLOCKS =
		(66 + 18 + 4) * CHAR_INTERVAL + RESET_CYCLES + STRETCH_CYCLES + 3;
	localparam longint WATCHDOG_NS = RUN_CLOCKS * CLK_PERIOD * 12 / 10;

	`include "beacon_vectors.svh"

	logic clock;
	logic rst_n;
	logic tx;
	serial_byte_t char;
	logic busy;

	int error_count;
	int pass_count;
	int fail_count;
	logic [7:0] lfsr_state;

	beacon_top dut0 (
		.clock (clock),
		.rst_n (rst_n),
		.tx    (tx),
		.char  (char),
		.busy  (busy)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		return {1'b0, state[7:1]} ^ (state[0] ? LFSR_TAPS : 8'h00);
	endfunction

	// one lfsr step per bit taken
	task automatic take_random_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_char(input string name, input serial_byte_t expected,
			input serial_byte_t actual);
		if (actual !== expected) begin
			$display("error at %0t ns: %s expected 8'h%02h, got 8'h%02h",
				$time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic release_reset();
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
	endtask

	// counts edges from the release of rst_n, line must stay idle meanwhile
	task automatic measure_start_delay(output bit started);
		int edge_idx;
		edge_idx = 0;
		started = 1'b0;
		while (!started && edge_idx <= START_DELAY + CLOCKS_PER_BIT) begin
			@(posedge clock);
			@(negedge clock);
			if (tx === 1'b0) begin
				started = 1'b1;
				check_count("first start edge", START_DELAY, edge_idx);
			end else begin
				check_bit("tx before first start", 1'b1, tx);
				check_bit("busy before first start", 1'b0, busy);
				edge_idx++;
			end
		end
		if (!started) begin
			$display("no start bit came out after the reset release");
			error_count++;
		end
	endtask

	task automatic wait_start(output bit found);
		int waited;
		waited = 0;
		found = 1'b0;
		while (!found && waited < START_WAIT_LIMIT) begin
			@(negedge clock);
			if (tx === 1'b0) begin
				found = 1'b1;
			end else begin
				waited++;
			end
		end
		if (!found) begin
			$display("tx stayed idle for %0d clocks, no start bit", START_WAIT_LIMIT);
			error_count++;
		end
	endtask

	// entered at the first falling clock edge of the start bit
	task automatic read_frame(output serial_byte_t value, output logic stop);
		value = '0;
		repeat (CLOCKS_PER_BIT / 2) @(negedge clock); // mid start bit
		check_bit("start bit", 1'b0, tx);
		check_bit("busy in frame", 1'b1, busy);
		for (int i = 0; i < 8; i++) begin
			repeat (CLOCKS_PER_BIT) @(negedge clock);
			value[i] = tx; // lsb first
			check_bit("busy in frame", 1'b1, busy);
		end
		repeat (CLOCKS_PER_BIT) @(negedge clock);
		stop = tx;
		check_bit("busy in frame", 1'b1, busy);
	endtask

	task automatic check_gap();
		repeat (GAP_CLOCKS) @(negedge clock);
		check_bit("busy between frames", 1'b0, busy);
		check_bit("tx between frames", 1'b1, tx);
	endtask

	task automatic run_pass(input int first, input int len, input bit already_started);
		serial_byte_t value;
		logic stop;
		bit found;
		for (int k = 0; k < len; k++) begin
			found = (k == 0) && already_started;
			if (!found) begin
				wait_start(found);
			end
			if (!found) begin
				return;
			end
			read_frame(value, stop);
			check_char($sformatf("char %0d", expect_table[first + k].idx),
				expect_table[first + k].ch, value);
			check_bit("stop bit", 1'b1, stop);
			check_gap();
			// header pins already show the next character
			check_char("char", expect_table[(first + k + 1) % TABLE_LEN].ch, char);
		end
	endtask

	task automatic reset_mid_frame();
		int offset;
		bit found;
		serial_byte_t value;
		logic stop;
		take_random_bits(6, offset);
		offset = offset + 4; // 4 to 67 clocks into the frame
		wait_start(found);
		if (!found) begin
			return;
		end
		repeat (offset) @(posedge clock);
		#(DRIVE_DELAY);
		rst_n = 1'b0;
		@(negedge clock);
		check_bit("tx in reset", 1'b1, tx);
		check_bit("busy in reset", 1'b0, busy);
		check_char("char in reset", expect_table[0].ch, char);
		release_reset();
		measure_start_delay(found);
		if (!found) begin
			return;
		end
		read_frame(value, stop);
		check_char("char after reset", expect_table[0].ch, value);
		check_bit("stop bit", 1'b1, stop);
	endtask

	initial begin
		int errors_before;
		bit first_started;
		clock = 1'b0;
		rst_n = 1'b0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		lfsr_state = LFSR_SEED;
		build_tables();

		errors_before = error_count;
		release_reset();
		measure_start_delay(first_started);
		finish_test("reset to first start bit", errors_before);

		for (int p = 0; p < PASS_COUNT; p++) begin
			errors_before = error_count;
			run_pass(pass_first[p], pass_len[p], (p == 0) && first_started);
			finish_test(pass_name[p], errors_before);
		end

		errors_before = error_count;
		reset_mid_frame();
		finish_test("reset inside a frame", errors_before);

		$display("%0d tests ok, %0d tests with errors", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// run length plus reset time, with some margin
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog ran out after %0d ns, the line stopped making progress", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule
